// File: common/mips_dev_pkg.sv
package mips_dev_pkg;

	// data and address words on the device bus
	typedef logic [31:0] word_t;

	// hardware interrupt lines 7..2, as the CPU sees them
	typedef logic [7:2] hwirq_t;

	// interrupt line of each timer inside hwirq_t
	localparam int HWIRQ_TIMER0 = 2;
	localparam int HWIRQ_TIMER1 = 3;

	// register select, taken from word offset bits 3:2
	typedef enum logic [1:0] {
		REG_CTRL   = 2'd0,
		REG_PRESET = 2'd1,
		REG_COUNT  = 2'd2,
		REG_NONE   = 2'd3
	} timer_reg_e;

	// CTRL layout
	localparam int CTRL_WIDTH   = 4;
	localparam int CTRL_EN      = 0;
	localparam int CTRL_MODE_LO = 1;
	localparam int CTRL_MODE_HI = 2;
	localparam int CTRL_IM      = 3;

	// mode codes in CTRL[2:1]
	localparam logic [1:0] MODE_ONESHOT = 2'd0;
	localparam logic [1:0] MODE_RELOAD  = 2'd1;

	// each timer decodes a 16 byte window
	localparam int TIMER_WIN_BITS = 4;

	// default timer windows
	localparam word_t TIMER0_BASE_DEFAULT = 32'h0000_7F00;
	localparam word_t TIMER1_BASE_DEFAULT = 32'h0000_7F10;

endpackage

// File: common/dev_bus_if.sv
interface dev_bus_if;
	import mips_dev_pkg::*;

	// register access from the bridge
	timer_reg_e reg_sel;
	logic       write_enable;
	word_t      write_data;

	// returned by the timer
	word_t      read_data;
	logic       irq;

	modport bridge (
		output reg_sel,
		output write_enable,
		output write_data,
		input  read_data,
		input  irq
	);

	modport timer (
		input  reg_sel,
		input  write_enable,
		input  write_data,
		output read_data,
		output irq
	);

endinterface

// File: bridge/bridge.sv
module bridge #(
	parameter mips_dev_pkg::word_t TIMER0_BASE = mips_dev_pkg::TIMER0_BASE_DEFAULT,
	parameter mips_dev_pkg::word_t TIMER1_BASE = mips_dev_pkg::TIMER1_BASE_DEFAULT
) (
	input  logic                   clk,
	input  logic                   rst_n,

	// CPU data-memory side
	input  logic                   bus_valid,
	output logic                   bus_ready,
	input  mips_dev_pkg::word_t    bus_addr,
	input  logic                   bus_write_enable,
	input  mips_dev_pkg::word_t    bus_write_data,

	output logic                   rsp_valid,
	output mips_dev_pkg::word_t    rsp_read_data,
	output logic                   rsp_error,
	output mips_dev_pkg::hwirq_t   hwirq,

	// timer register buses
	dev_bus_if.bridge              timer0,
	dev_bus_if.bridge              timer1
);
	import mips_dev_pkg::*;

	logic       accept;
	logic       aligned;
	logic       hit0;
	logic       hit1;
	logic       mapped;
	timer_reg_e offset_sel;
	word_t      sel_read_data;

	assign accept = bus_valid & bus_ready;

	// address decode
	assign aligned = (bus_addr[1:0] == 2'b00);
	assign hit0    = (bus_addr[31:TIMER_WIN_BITS] == TIMER0_BASE[31:TIMER_WIN_BITS]);
	assign hit1    = (bus_addr[31:TIMER_WIN_BITS] == TIMER1_BASE[31:TIMER_WIN_BITS]);
	assign mapped  = aligned & (hit0 | hit1);

	// word offset inside the window picks the register
	assign offset_sel = timer_reg_e'(bus_addr[TIMER_WIN_BITS-1:2]);

	// timer0 has priority should the windows ever overlap
	assign timer0.reg_sel      = (mapped && hit0) ? offset_sel : REG_NONE;
	assign timer0.write_data   = bus_write_data;
	assign timer0.write_enable = accept & bus_write_enable & mapped & hit0;

	assign timer1.reg_sel      = (mapped && !hit0 && hit1) ? offset_sel : REG_NONE;
	assign timer1.write_data   = bus_write_data;
	assign timer1.write_enable = accept & bus_write_enable & mapped & !hit0 & hit1;

	// deselected timers read zero, so this mux is just a priority pick
	always_comb begin
		sel_read_data = '0;
		if (hit0) begin
			sel_read_data = timer0.read_data;
		end else if (hit1) begin
			sel_read_data = timer1.read_data;
		end
	end

	// no stalls, ready once out of reset
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			bus_ready <= 1'b0;
		end else begin
			bus_ready <= 1'b1;
		end
	end

	// one response per accepted request, the cycle after
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rsp_valid <= 1'b0;
			rsp_error <= 1'b0;
		end else begin
			rsp_valid <= accept;
			rsp_error <= accept & !mapped;
		end
	end

	// value as it was before the accepting edge
	always_ff @(posedge clk) begin
		if (accept) begin
			if (bus_write_enable || !mapped) begin
				rsp_read_data <= '0;
			end else begin
				rsp_read_data <= sel_read_data;
			end
		end
	end

	// interrupt vector, unused lines stay low
	always_comb begin
		hwirq               = '0;
		hwirq[HWIRQ_TIMER0] = timer0.irq;
		hwirq[HWIRQ_TIMER1] = timer1.irq;
	end

endmodule

// File: timer/timer.sv
module timer (
	input  logic      clk,
	input  logic      rst_n,
	dev_bus_if.timer  bus
);
	import mips_dev_pkg::*;

	logic [CTRL_WIDTH-1:0] ctrl;
	word_t                 preset;
	word_t                 count;
	logic                  pending;

	logic                  enable;
	logic [1:0]            mode;
	logic                  mask;
	logic                  wr_ctrl;
	logic                  wr_preset;

	// CTRL fields
	assign enable = ctrl[CTRL_EN];
	assign mode   = ctrl[CTRL_MODE_HI:CTRL_MODE_LO];
	assign mask   = ctrl[CTRL_IM];

	// COUNT and the unused offset ignore writes
	assign wr_ctrl   = bus.write_enable && (bus.reg_sel == REG_CTRL);
	assign wr_preset = bus.write_enable && (bus.reg_sel == REG_PRESET);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ctrl    <= '0;
			preset  <= '0;
			count   <= '0;
			pending <= 1'b0;
		end else if (wr_preset) begin
			// new preset restarts the count
			preset <= bus.write_data;
			count  <= bus.write_data;
		end else if (wr_ctrl) begin
			// rewriting CTRL acknowledges the interrupt
			ctrl    <= bus.write_data[CTRL_WIDTH-1:0];
			pending <= 1'b0;
		end else if (enable) begin
			if (count != '0) begin
				count <= count - word_t'(1);
			end else begin
				pending <= 1'b1;
				case (mode)
					MODE_ONESHOT: begin
						ctrl[CTRL_EN] <= 1'b0;
					end
					MODE_RELOAD: begin
						count <= preset;
					end
					default: begin
						// reserved codes stop like one-shot
						ctrl[CTRL_EN] <= 1'b0;
					end
				endcase
			end
		end
	end

	// register read back
	always_comb begin
		case (bus.reg_sel)
			REG_CTRL: begin
				bus.read_data = word_t'(ctrl);
			end
			REG_PRESET: begin
				bus.read_data = preset;
			end
			REG_COUNT: begin
				bus.read_data = count;
			end
			default: begin
				bus.read_data = '0;
			end
		endcase
	end

	// masked interrupt
	assign bus.irq = pending & mask;

endmodule

// File: source/mips_dev.sv
module mips_dev #(
	parameter mips_dev_pkg::word_t TIMER0_BASE = mips_dev_pkg::TIMER0_BASE_DEFAULT,
	parameter mips_dev_pkg::word_t TIMER1_BASE = mips_dev_pkg::TIMER1_BASE_DEFAULT
) (
	input  logic                 clk,
	input  logic                 rst_n,

	// CPU data-memory request
	input  logic                 bus_valid,
	output logic                 bus_ready,
	input  mips_dev_pkg::word_t  bus_addr,
	input  logic                 bus_write_enable,
	input  mips_dev_pkg::word_t  bus_write_data,

	// response, one cycle after accept
	output logic                 rsp_valid,
	output mips_dev_pkg::word_t  rsp_read_data,
	output logic                 rsp_error,

	output mips_dev_pkg::hwirq_t hwirq
);

	// bridge to timer buses
	dev_bus_if timer0_bus ();
	dev_bus_if timer1_bus ();

	bridge #(
		.TIMER0_BASE(TIMER0_BASE),
		.TIMER1_BASE(TIMER1_BASE)
	) bridge (
		.clk(clk),
		.rst_n(rst_n),

		.bus_valid(bus_valid),
		.bus_ready(bus_ready),
		.bus_addr(bus_addr),
		.bus_write_enable(bus_write_enable),
		.bus_write_data(bus_write_data),

		.rsp_valid(rsp_valid),
		.rsp_read_data(rsp_read_data),
		.rsp_error(rsp_error),
		.hwirq(hwirq),

		.timer0(timer0_bus.bridge),
		.timer1(timer1_bus.bridge)
	);

	timer timer0 (
		.clk(clk),
		.rst_n(rst_n),
		.bus(timer0_bus.timer)
	);

	timer timer1 (
		.clk(clk),
		.rst_n(rst_n),
		.bus(timer1_bus.timer)
	);

endmodule

// File: dv/tb_mips_dev.sv
module tb_mips_dev;
	import mips_dev_pkg::*;

	localparam word_t T0      = TIMER0_BASE_DEFAULT;
	localparam word_t T1      = TIMER1_BASE_DEFAULT;
	localparam int    TIMEOUT = 40;

	logic   clk = 1'b0;
	logic   rst_n;
	logic   bus_valid;
	logic   bus_ready;
	word_t  bus_addr;
	logic   bus_write_enable;
	word_t  bus_write_data;
	logic   rsp_valid;
	word_t  rsp_read_data;
	logic   rsp_error;
	hwirq_t hwirq;

	// timer model with one entry per timer
	logic [3:0] m_ctrl [2];
	word_t      m_preset [2];
	word_t      m_count [2];
	logic       m_pend [2];
	logic       m_ready;
	logic       m_accept;
	int         m_tgt;

	// what the DUT should show at the next falling edge
	logic   exp_valid;
	logic   exp_error;
	word_t  exp_data;
	hwirq_t exp_hwirq;
	int     req_count = 0;
	int     rsp_count = 0;
	logic   checking = 1'b0;

	word_t  rd;
	word_t  addr;
	logic   err;
	int     n;

	always #10 clk = ~clk;

	mips_dev uut (
		.clk(clk),
		.rst_n(rst_n),
		.bus_valid(bus_valid),
		.bus_ready(bus_ready),
		.bus_addr(bus_addr),
		.bus_write_enable(bus_write_enable),
		.bus_write_data(bus_write_data),
		.rsp_valid(rsp_valid),
		.rsp_read_data(rsp_read_data),
		.rsp_error(rsp_error),
		.hwirq(hwirq)
	);

	task automatic abort_run();
		$display("Test FAILED");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic wrong_value(input string what, input word_t expected, input word_t actual);
		$display("Mismatch at time %0t: %s expected %0h, got %0h", $time, what, expected, actual);
		abort_run();
	endtask

	task automatic stuck_wait(input string what);
		$display("Error at time %0t: timed out waiting for %s", $time, what);
		abort_run();
	endtask

	// timer index for a word-aligned address inside a window or -1
	function automatic int target_of(input word_t a);
		if (a[1:0] != 2'b00) begin
			return -1;
		end
		if (a >= T0 && a < T0 + 32'd16) begin
			return 0;
		end
		if (a >= T1 && a < T1 + 32'd16) begin
			return 1;
		end
		return -1;
	endfunction

	function automatic logic [1:0] offset_of(input word_t a, input int t);
		word_t rel;
		rel = a - ((t == 0) ? T0 : T1);
		return rel[3:2];
	endfunction

	function automatic word_t model_read(input int t, input logic [1:0] off);
		case (off)
			2'd0: return {28'd0, m_ctrl[t]};
			2'd1: return m_preset[t];
			2'd2: return m_count[t];
			default: return '0;
		endcase
	endfunction

	// in windows, next to them, misaligned or anywhere
	function automatic word_t rand_addr();
		word_t base;
		int    sel;
		base = ($urandom % 2 == 0) ? T0 : T1;
		sel  = int'($urandom % 5);
		case (sel)
			0, 1: return base + 32'(4 * ($urandom % 4));
			2: return base + 32'($urandom % 16);
			3: return base + 32'd16 + 32'(4 * ($urandom % 4));
			default: return $urandom;
		endcase
	endfunction

	// short counts with mode bit 2 clear so only the two defined modes occur
	function automatic word_t rand_data();
		return $urandom & 32'h0000_003B;
	endfunction

	task automatic step_timer(input int t, input logic wr, input logic [1:0] off,
			input word_t data);
		if (wr && off == 2'd1) begin
			m_preset[t] = data;
			m_count[t]  = data;
		end else if (wr && off == 2'd0) begin
			m_ctrl[t] = data[3:0];
			m_pend[t] = 1'b0;
		end else if (m_ctrl[t][CTRL_EN]) begin
			if (m_count[t] != 32'd0) begin
				m_count[t] = m_count[t] - 32'd1;
			end else begin
				m_pend[t] = 1'b1;
				if (m_ctrl[t][CTRL_MODE_HI:CTRL_MODE_LO] == MODE_RELOAD) begin
					m_count[t] = m_preset[t];
				end else begin
					m_ctrl[t][CTRL_EN] = 1'b0;
				end
			end
		end
	endtask

	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int t = 0; t < 2; t++) begin
				m_ctrl[t]   = '0;
				m_preset[t] = '0;
				m_count[t]  = '0;
				m_pend[t]   = 1'b0;
			end
			m_ready   = 1'b0;
			exp_valid = 1'b0;
			exp_error = 1'b0;
			exp_data  = '0;
			exp_hwirq = '0;
		end else begin
			m_tgt    = target_of(bus_addr);
			m_accept = bus_valid && m_ready;
			// response reflects the state before this edge
			exp_valid = m_accept;
			exp_error = m_accept && (m_tgt < 0);
			exp_data  = '0;
			if (m_accept) begin
				if (m_tgt >= 0 && !bus_write_enable) begin
					exp_data = model_read(m_tgt, offset_of(bus_addr, m_tgt));
				end
			end
			for (int t = 0; t < 2; t++) begin
				step_timer(t, m_accept && bus_write_enable && (m_tgt == t),
					offset_of(bus_addr, t), bus_write_data);
			end
			m_ready   = 1'b1;
			exp_hwirq = '0;
			exp_hwirq[HWIRQ_TIMER0] = m_pend[0] && m_ctrl[0][CTRL_IM];
			exp_hwirq[HWIRQ_TIMER1] = m_pend[1] && m_ctrl[1][CTRL_IM];
		end
	end

	always @(negedge clk) begin
		if (checking) begin
			assert (bus_ready == m_ready)
				else wrong_value("bus_ready", 32'(m_ready), 32'(bus_ready));
			assert (rsp_valid == exp_valid)
				else wrong_value("rsp_valid", 32'(exp_valid), 32'(rsp_valid));
			if (exp_valid) begin
				assert (rsp_error == exp_error)
					else wrong_value("rsp_error", 32'(exp_error), 32'(rsp_error));
				assert (rsp_read_data == exp_data)
					else wrong_value("rsp_read_data", exp_data, rsp_read_data);
			end
			assert (hwirq == exp_hwirq)
				else wrong_value("hwirq", 32'(exp_hwirq), 32'(hwirq));
			if (rsp_valid) begin
				rsp_count++;
			end
		end
	end

	task automatic drive_idle();
		bus_valid        = 1'b0;
		bus_addr         = '0;
		bus_write_enable = 1'b0;
		bus_write_data   = '0;
	endtask

	// one request that returns at the falling edge showing its response
	task automatic bus_access(input word_t a, input logic we, input word_t data,
			output word_t rdata, output logic error);
		int waited;
		bus_valid        = 1'b1;
		bus_addr         = a;
		bus_write_enable = we;
		bus_write_data   = data;
		req_count++;
		@(negedge clk);
		drive_idle();
		waited = 0;
		while (!rsp_valid) begin
			if (waited >= TIMEOUT) begin
				stuck_wait("a bus response");
			end else begin
				@(negedge clk);
				waited++;
			end
		end
		rdata = rsp_read_data;
		error = rsp_error;
	endtask

	task automatic write_reg(input word_t a, input word_t data);
		word_t rdata;
		logic  error;
		bus_access(a, 1'b1, data, rdata, error);
		assert (!error) else wrong_value("rsp_error on write", '0, 32'(error));
	endtask

	task automatic read_reg(input word_t a, output word_t rdata);
		logic error;
		bus_access(a, 1'b0, '0, rdata, error);
		assert (!error) else wrong_value("rsp_error on read", '0, 32'(error));
	endtask

	// consecutive requests with one response per cycle
	task automatic burst(input int len);
		for (int i = 0; i < len; i++) begin
			bus_valid        = 1'b1;
			bus_addr         = rand_addr();
			bus_write_enable = 1'($urandom % 2);
			bus_write_data   = rand_data();
			req_count++;
			@(negedge clk);
			assert (rsp_valid) else wrong_value("rsp_valid in burst", 32'd1, '0);
		end
		drive_idle();
		@(negedge clk);
	endtask

	initial begin
		void'($urandom(97968));
		drive_idle();
		rst_n = 1'b0;
		repeat (3) begin
			@(posedge clk);
		end
		checking = 1'b1;
		@(negedge clk);
		rst_n = 1'b1;
		n = 0;
		while (!bus_ready) begin
			if (n >= TIMEOUT) begin
				stuck_wait("bus_ready after reset");
			end else begin
				@(negedge clk);
				n++;
			end
		end

		for (int i = 0; i < 6; i++) begin
			addr = ((i < 3) ? T0 : T1) + 32'(4 * (i % 3));
			read_reg(addr, rd);
			assert (rd == '0) else wrong_value("register after reset", '0, rd);
		end

		// one-shot on timer0 with the interrupt unmasked
		write_reg(T0 + 32'h4, 32'd5);
		write_reg(T0, 32'h9);
		for (int i = 0; i < 8; i++) begin
			read_reg(T0 + 32'h8, rd);
		end
		read_reg(T0, rd);
		assert (rd[CTRL_EN] == 1'b0) else wrong_value("CTRL enable after expiry", '0, rd);
		assert (hwirq[HWIRQ_TIMER0]) else wrong_value("hwirq timer0", 32'd1, 32'(hwirq));

		// timer1 expires masked while timer0 is acknowledged
		write_reg(T1 + 32'h4, 32'd2);
		write_reg(T1, 32'h1);
		repeat (6) begin
			@(negedge clk);
		end
		assert (!hwirq[HWIRQ_TIMER1]) else wrong_value("masked hwirq", '0, 32'(hwirq));
		write_reg(T0, 32'h0);
		assert (!hwirq[HWIRQ_TIMER0]) else wrong_value("hwirq after ack", '0, 32'(hwirq));

		// auto-reload on timer1
		write_reg(T1 + 32'h4, 32'd3);
		write_reg(T1, 32'hB);
		n = 0;
		while (!hwirq[HWIRQ_TIMER1]) begin
			if (n >= TIMEOUT) begin
				stuck_wait("the timer1 interrupt");
			end else begin
				@(negedge clk);
				n++;
			end
		end
		for (int i = 0; i < 6; i++) begin
			read_reg(T1 + 32'h8, rd);
		end
		write_reg(T1, 32'hB);
		assert (!hwirq[HWIRQ_TIMER1]) else wrong_value("hwirq after ack", '0, 32'(hwirq));
		write_reg(T1, 32'h0);

		// random accesses with random gaps
		for (int i = 0; i < 200; i++) begin
			addr = rand_addr();
			bus_access(addr, 1'($urandom % 2), rand_data(), rd, err);
			assert (err == (target_of(addr) < 0))
				else wrong_value("rsp_error for address", 32'(target_of(addr) < 0), 32'(err));
			repeat (int'($urandom % 4)) begin
				@(negedge clk);
			end
		end

		burst(80);
		@(negedge clk);
		assert (rsp_count == req_count)
			else wrong_value("response count", 32'(req_count), 32'(rsp_count));
		$display("Test OK");
		$finish;
	end

endmodule

// File: src.f
common/mips_dev_pkg.sv
common/dev_bus_if.sv
bridge/bridge.sv
timer/timer.sv
source/mips_dev.sv
dv/tb_mips_dev.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_mips_dev
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -qx "Test OK" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
